//--- Bender.yml
package:
  name: simd_lane

sources:
  - design/tpu_types_pkg.sv
  - design/tpu_isa_pkg.sv
  - design/axil_lane_port.sv
  - design/issue_ctrl.sv
  - design/lane_regfile.sv
  - design/path_sel.sv
  - design/lane_exec.sv
  - design/simd_lane_top.sv
  - target: simulation
    files:
      - testbench/simd_lane_props.sv
      - testbench/tb_simd_lane.sv

//--- design/axil_lane_port.sv
////////////////////
// AXI4-Lite host port
////////////////////

module axil_lane_port #(
	parameter int NUM_LANES = 4
)(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      awvalid,
	output logic                      awready,
	input  tpu_isa_pkg::axi_addr_t    awaddr,
	input  logic                      wvalid,
	output logic                      wready,
	input  tpu_types_pkg::data_t      wdata,
	output logic                      bvalid,
	input  logic                      bready,
	output tpu_isa_pkg::axi_resp_t    bresp,
	input  logic                      arvalid,
	output logic                      arready,
	input  tpu_isa_pkg::axi_addr_t    araddr,
	output logic                      rvalid,
	input  logic                      rready,
	output tpu_types_pkg::data_t      rdata,
	output tpu_isa_pkg::axi_resp_t    rresp,
	input  logic                      busy,
	output logic                      cmd_valid,
	output tpu_isa_pkg::instr_t       cmd_word,
	output logic                      host_we,
	output tpu_types_pkg::lane_idx_t  host_lane,
	output tpu_types_pkg::reg_idx_t   host_reg,
	output tpu_types_pkg::data_t      host_wdata,
	output tpu_types_pkg::lane_idx_t  rd_lane,
	output tpu_types_pkg::reg_idx_t   rd_reg,
	input  tpu_types_pkg::data_t [NUM_LANES-1:0] host_rdata,
	output tpu_types_pkg::data_t      scalar
);
	import tpu_types_pkg::*;
	import tpu_isa_pkg::*;

	function automatic logic in_reg_window(input axi_addr_t addr);
		return ((addr - ADDR_REG_BASE) < axi_addr_t'(NUM_LANES * 32)) && (addr[1:0] == 2'b00);
	endfunction

	axi_addr_t wr_off;
	axi_addr_t rd_off;
	logic      wr_hit_reg;
	logic      wr_hit_cmd;
	logic      wr_hit_scalar;
	logic      wr_hit_status;
	logic      wr_mapped;
	logic      wr_go;
	logic      rd_go;
	logic      rd_err;
	data_t     rd_word;
	data_t     cmd_q;

	////////////////////
	// Write channel
	////////////////////

	assign wr_off        = awaddr - ADDR_REG_BASE;
	assign wr_hit_reg    = in_reg_window(awaddr);
	assign wr_hit_cmd    = (awaddr == ADDR_CMD);
	assign wr_hit_scalar = (awaddr == ADDR_SCALAR);
	assign wr_hit_status = (awaddr == ADDR_STATUS);	// Read only, write ignored
	assign wr_mapped     = wr_hit_reg || wr_hit_cmd || wr_hit_scalar || wr_hit_status;

	// AW and W taken together, command held off while busy
	assign wr_go   = awvalid && wvalid && !bvalid && !(wr_hit_cmd && busy);
	assign awready = wr_go;
	assign wready  = wr_go;

	assign cmd_valid  = wr_go && wr_hit_cmd;
	assign cmd_word   = instr_t'(wdata);
	assign host_we    = wr_go && wr_hit_reg;
	assign host_lane  = wr_off[6:5];	// Lane above the 8 word slots
	assign host_reg   = wr_off[4:2];
	assign host_wdata = wdata;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			scalar <= '0;
			cmd_q  <= '0;
		end else begin
			if (wr_go) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (wr_go && wr_hit_scalar) begin
				scalar <= wdata;	// Broadcast to every lane
			end
			if (cmd_valid) begin
				cmd_q <= wdata;		// Last issued command, readable
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wr_go) begin
			bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
		end
	end

	////////////////////
	// Read channel
	////////////////////

	assign arready = !rvalid;		// One response in flight
	assign rd_go   = arvalid && arready;
	assign rd_off  = araddr - ADDR_REG_BASE;
	assign rd_lane = rd_off[6:5];
	assign rd_reg  = rd_off[4:2];

	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		if (in_reg_window(araddr)) begin
			rd_word = host_rdata[rd_lane];
		end else if (araddr == ADDR_CMD) begin
			rd_word = cmd_q;
		end else if (araddr == ADDR_SCALAR) begin
			rd_word = scalar;
		end else if (araddr == ADDR_STATUS) begin
			rd_word = data_t'(busy);
		end else begin
			rd_err = 1'b1;		// Unmapped, data stays 0
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_go) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_go) begin
			rdata <= rd_word;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

//--- design/issue_ctrl.sv
////////////////////
// Instruction issue FSM
////////////////////

module issue_ctrl (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     cmd_valid,
	input  tpu_isa_pkg::instr_t      cmd_word,
	output logic                     busy,
	output logic                     rd_en,
	output tpu_types_pkg::reg_idx_t  src1_reg,
	output tpu_types_pkg::reg_idx_t  src2_reg,
	output logic                     ex_en,
	output tpu_isa_pkg::opcode_e     opcode,
	output tpu_types_pkg::path_t     src_path,
	output tpu_types_pkg::path_t     wb_path,
	output logic                     wb_en,
	output tpu_types_pkg::reg_idx_t  dst_reg
);
	import tpu_isa_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		EXEC,
		WB
	} state_e;

	state_e state;
	state_e state_nxt;
	instr_t instr_q;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (cmd_valid) state_nxt = READ;
			READ: state_nxt = EXEC;
			EXEC: state_nxt = WB;
			WB:   state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Fields stay put for the whole instruction
	always_ff @(posedge clock) begin
		if (state == IDLE && cmd_valid) begin
			instr_q <= cmd_word;
		end
	end

	assign busy  = (state != IDLE);
	assign rd_en = (state == READ);		// Stage 1
	assign ex_en = (state == EXEC);		// Stage 2
	assign wb_en = (state == WB);		// Stage 3

	assign src1_reg = instr_q.src1;
	assign src2_reg = instr_q.src2;
	assign opcode   = instr_q.opcode;
	assign src_path = instr_q.src_path;
	assign wb_path  = instr_q.wb_path;
	assign dst_reg  = instr_q.dst;

endmodule

//--- design/lane_exec.sv
////////////////////
// Lane ALU
////////////////////

module lane_exec (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  ex_en,
	input  tpu_isa_pkg::opcode_e  opcode,
	input  tpu_types_pkg::data_t  opnd_a,
	input  tpu_types_pkg::data_t  opnd_b,
	output tpu_types_pkg::data_t  result
);
	import tpu_isa_pkg::*;

	// Result held until the next instruction executes
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			result <= '0;
		end else if (ex_en) begin
			case (opcode)
				OP_ADD:  result <= opnd_a + opnd_b;
				OP_SUB:  result <= opnd_a - opnd_b;
				OP_MUL:  result <= opnd_a * opnd_b;	// Low 32 bits
				OP_AND:  result <= opnd_a & opnd_b;
				OP_XOR:  result <= opnd_a ^ opnd_b;
				OP_PASS: result <= opnd_a;
				default: result <= '0;			// Undefined codes
			endcase
		end
	end

endmodule

//--- design/lane_regfile.sv
////////////////////
// Lane register file
////////////////////

module lane_regfile (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     rd_en,
	input  tpu_types_pkg::reg_idx_t  src1_reg,
	input  tpu_types_pkg::reg_idx_t  src2_reg,
	output tpu_types_pkg::data_t     src1_data,
	output tpu_types_pkg::data_t     src2_data,
	input  logic                     wb_en,
	input  tpu_types_pkg::reg_idx_t  dst_reg,
	input  tpu_types_pkg::data_t     wb_data,
	input  logic                     host_we,
	input  tpu_types_pkg::reg_idx_t  host_reg,
	input  tpu_types_pkg::data_t     host_wdata,
	input  tpu_types_pkg::reg_idx_t  rd_reg,
	output tpu_types_pkg::data_t     host_rdata
);
	import tpu_types_pkg::*;

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (host_we) begin
				regs[host_reg] <= host_wdata;
			end
			if (wb_en) begin
				regs[dst_reg] <= wb_data;	// Pipeline wins a clash
			end
		end
	end

	// Stage 1 operand registers, also seen by the other lanes
	always_ff @(posedge clock) begin
		if (rd_en) begin
			src1_data <= regs[src1_reg];
			src2_data <= regs[src2_reg];
		end
	end

	assign host_rdata = regs[rd_reg];

endmodule

//--- design/path_sel.sv
////////////////////
// Operand and write-back path select
////////////////////

module path_sel #(
	parameter int NUM_LANES = 4,
	parameter int LANE_ID   = 0
)(
	input  tpu_types_pkg::path_t  src_path,
	input  tpu_types_pkg::path_t  wb_path,
	input  tpu_types_pkg::data_t  scalar,
	input  tpu_types_pkg::data_t  src1_data,
	input  tpu_types_pkg::data_t  src2_data,
	input  tpu_types_pkg::data_t [NUM_LANES-1:0] lane_src1,
	input  tpu_types_pkg::data_t [NUM_LANES-1:0] lane_src2,
	input  tpu_types_pkg::data_t [NUM_LANES-1:0] lane_result,
	input  tpu_types_pkg::data_t  alu_result,
	output tpu_types_pkg::data_t  opnd_a,
	output tpu_types_pkg::data_t  opnd_b,
	output tpu_types_pkg::data_t  wb_data
);
	import tpu_types_pkg::*;

	localparam int ROT_W = $bits(lane_idx_t);

	lane_idx_t src_rot;
	lane_idx_t wb_rot;
	lane_idx_t src_lane;
	lane_idx_t wb_lane;
	data_t     local_a;
	data_t     local_wb;

	// Neighbour lane is (own lane + rotation) mod lane count
	assign src_rot  = src_path[ROT_W-1:0];
	assign wb_rot   = wb_path[ROT_W-1:0];
	assign src_lane = lane_idx_t'((LANE_ID + int'(src_rot)) % NUM_LANES);
	assign wb_lane  = lane_idx_t'((LANE_ID + int'(wb_rot)) % NUM_LANES);

	// Local choice drives operand A, operand B keeps source 2
	always_comb begin
		case (src_path[1:0])
			PATH_SCALAR: local_a = scalar;
			PATH_SRC1:   local_a = src1_data;
			default:     local_a = src2_data;
		endcase
	end

	always_comb begin
		case (wb_path[1:0])
			PATH_SCALAR: local_wb = alu_result;	// Code 0 is the ALU on write-back
			PATH_SRC1:   local_wb = src1_data;
			default:     local_wb = src2_data;
		endcase
	end

	assign opnd_a  = src_path[PATH_ROT_BIT] ? lane_src1[src_lane] : local_a;
	assign opnd_b  = src_path[PATH_ROT_BIT] ? lane_src2[src_lane] : src2_data;
	assign wb_data = wb_path[PATH_ROT_BIT] ? lane_result[wb_lane] : local_wb;

endmodule

//--- design/simd_lane_top.sv
////////////////////
// SIMD lane array
////////////////////

module simd_lane_top #(
	parameter int NUM_LANES = 4
)(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    awvalid,
	output logic                    awready,
	input  tpu_isa_pkg::axi_addr_t  awaddr,
	input  logic                    wvalid,
	output logic                    wready,
	input  tpu_types_pkg::data_t    wdata,
	output logic                    bvalid,
	input  logic                    bready,
	output tpu_isa_pkg::axi_resp_t  bresp,
	input  logic                    arvalid,
	output logic                    arready,
	input  tpu_isa_pkg::axi_addr_t  araddr,
	output logic                    rvalid,
	input  logic                    rready,
	output tpu_types_pkg::data_t    rdata,
	output tpu_isa_pkg::axi_resp_t  rresp
);
	import tpu_types_pkg::*;
	import tpu_isa_pkg::*;

	logic      busy;
	logic      cmd_valid;
	instr_t    cmd_word;
	logic      host_we;
	lane_idx_t host_lane;
	reg_idx_t  host_reg;
	data_t     host_wdata;
	reg_idx_t  rd_reg;
	data_t     scalar;

	logic      rd_en;
	reg_idx_t  src1_reg;
	reg_idx_t  src2_reg;
	logic      ex_en;
	opcode_e   opcode;
	path_t     src_path;
	path_t     wb_path;
	logic      wb_en;
	reg_idx_t  dst_reg;

	// Per lane values shared across the array
	wire data_t [NUM_LANES-1:0] host_rdata;
	wire data_t [NUM_LANES-1:0] lane_src1;
	wire data_t [NUM_LANES-1:0] lane_src2;
	wire data_t [NUM_LANES-1:0] lane_result;

	axil_lane_port #(
		.NUM_LANES (NUM_LANES)
	) u_port (
		.clock      (clock),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awready    (awready),
		.awaddr     (awaddr),
		.wvalid     (wvalid),
		.wready     (wready),
		.wdata      (wdata),
		.bvalid     (bvalid),
		.bready     (bready),
		.bresp      (bresp),
		.arvalid    (arvalid),
		.arready    (arready),
		.araddr     (araddr),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rresp      (rresp),
		.busy       (busy),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.host_we    (host_we),
		.host_lane  (host_lane),
		.host_reg   (host_reg),
		.host_wdata (host_wdata),
		.rd_lane    (),			// Lane pick done inside the port
		.rd_reg     (rd_reg),
		.host_rdata (host_rdata),
		.scalar     (scalar)
	);

	issue_ctrl u_ctrl (
		.clock     (clock),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_word  (cmd_word),
		.busy      (busy),
		.rd_en     (rd_en),
		.src1_reg  (src1_reg),
		.src2_reg  (src2_reg),
		.ex_en     (ex_en),
		.opcode    (opcode),
		.src_path  (src_path),
		.wb_path   (wb_path),
		.wb_en     (wb_en),
		.dst_reg   (dst_reg)
	);

	////////////////////
	// Lane array
	////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		logic  lane_we;
		data_t opnd_a;
		data_t opnd_b;
		data_t wb_data;

		assign lane_we = host_we && (host_lane == lane_idx_t'(i));

		lane_regfile u_regfile (
			.clock      (clock),
			.rst_n      (rst_n),
			.rd_en      (rd_en),
			.src1_reg   (src1_reg),
			.src2_reg   (src2_reg),
			.src1_data  (lane_src1[i]),
			.src2_data  (lane_src2[i]),
			.wb_en      (wb_en),
			.dst_reg    (dst_reg),
			.wb_data    (wb_data),
			.host_we    (lane_we),
			.host_reg   (host_reg),
			.host_wdata (host_wdata),
			.rd_reg     (rd_reg),
			.host_rdata (host_rdata[i])
		);

		path_sel #(
			.NUM_LANES (NUM_LANES),
			.LANE_ID   (i)
		) u_path (
			.src_path    (src_path),
			.wb_path     (wb_path),
			.scalar      (scalar),
			.src1_data   (lane_src1[i]),
			.src2_data   (lane_src2[i]),
			.lane_src1   (lane_src1),
			.lane_src2   (lane_src2),
			.lane_result (lane_result),
			.alu_result  (lane_result[i]),
			.opnd_a      (opnd_a),
			.opnd_b      (opnd_b),
			.wb_data     (wb_data)
		);

		lane_exec u_exec (
			.clock  (clock),
			.rst_n  (rst_n),
			.ex_en  (ex_en),
			.opcode (opcode),
			.opnd_a (opnd_a),
			.opnd_b (opnd_b),
			.result (lane_result[i])
		);
	end

endmodule

//--- design/tpu_isa_pkg.sv
////////////////////
// Instruction set and register map
////////////////////

package tpu_isa_pkg;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_MUL  = 3'd2,
		OP_AND  = 3'd3,
		OP_XOR  = 3'd4,
		OP_PASS = 3'd5
	} opcode_e;

	// Command word as written to ADDR_CMD
	typedef struct packed {
		logic [2:0]           rsvd_31;	// 31:29
		tpu_types_pkg::path_t wb_path;	// 28:24
		logic [2:0]           rsvd_23;	// 23:21
		tpu_types_pkg::path_t src_path;	// 20:16
		logic                 rsvd_15;
		tpu_types_pkg::reg_idx_t src2;	// 14:12
		logic                 rsvd_11;
		tpu_types_pkg::reg_idx_t src1;	// 10:8
		logic                 rsvd_7;
		tpu_types_pkg::reg_idx_t dst;	// 6:4
		logic                 rsvd_3;
		opcode_e              opcode;	// 2:0
	} instr_t;

	typedef logic [11:0] axi_addr_t;	// Byte address on the AXI4-Lite port
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	localparam axi_addr_t ADDR_REG_BASE = 12'h000;	// (lane*8+reg)*4 from here
	localparam axi_addr_t ADDR_CMD      = 12'h100;
	localparam axi_addr_t ADDR_SCALAR   = 12'h104;
	localparam axi_addr_t ADDR_STATUS   = 12'h108;	// Bit 0 is busy

endpackage

//--- design/tpu_types_pkg.sv
////////////////////
// Lane datapath types
////////////////////

package tpu_types_pkg;

	typedef logic [31:0] data_t;		// One lane word
	typedef logic [2:0]  reg_idx_t;		// Register number inside a lane
	typedef logic [1:0]  lane_idx_t;	// Lane number, also the rotation amount
	typedef logic [4:0]  path_t;		// Path select, see layout below

	localparam int NUM_REGS = 8;		// Registers per lane

	// Path select layout
	//   bit 4     take the value from a rotated lane
	//   bits 3:0  rotation, low lane_idx_t bits count
	//   bits 1:0  local choice when bit 4 is clear
	localparam int PATH_ROT_BIT = 4;

	localparam logic [1:0] PATH_SCALAR = 2'd0;	// Scalar, or ALU result on write-back
	localparam logic [1:0] PATH_SRC1   = 2'd1;	// Local source 1
	localparam logic [1:0] PATH_SRC2   = 2'd2;	// Local source 2, code 3 too

endpackage

//--- sources.f
design/tpu_types_pkg.sv
design/tpu_isa_pkg.sv
design/axil_lane_port.sv
design/issue_ctrl.sv
design/lane_regfile.sv
design/path_sel.sv
design/lane_exec.sv
design/simd_lane_top.sv
testbench/simd_lane_props.sv
testbench/tb_simd_lane.sv

//--- testbench/simd_lane_props.sv
////////////////////
// SIMD lane protocol checks
////////////////////

module simd_lane_props (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    awvalid,
	input  logic                    awready,
	input  tpu_isa_pkg::axi_addr_t  awaddr,
	input  logic                    wvalid,
	input  logic                    wready,
	input  tpu_types_pkg::data_t    wdata,
	input  logic                    bvalid,
	input  logic                    bready,
	input  logic                    arvalid,
	input  logic                    arready,
	input  logic                    rvalid,
	input  logic                    rready,
	input  tpu_types_pkg::data_t    rdata,
	input  logic                    busy,
	input  logic                    cmd_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	import tpu_isa_pkg::*;

	int fail_count = 0;		// Failed assertions so far

	////////////////////
	// Reset
	////////////////////

	a_reset_idle: assert property (@(posedge clock) !rst_n |=> !bvalid && !rvalid && !busy)
		else begin
			$error("bvalid, rvalid or busy high after a reset cycle");
			fail_count++;
		end

	////////////////////
	// Busy and back-pressure
	////////////////////

	// No command taken while the previous one is in flight
	a_cmd_stall: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && awready && (awaddr == ADDR_CMD)
		|=> (!awvalid || (awaddr != ADDR_CMD) || (!awready && !wready))[*3])
		else begin
			$error("command write accepted while the previous command was busy");
			fail_count++;
		end
	// Three pipeline cycles, then idle
	a_busy_len: assert property (@(posedge clock) disable iff (!rst_n)
		cmd_valid |=> busy ##1 busy ##1 busy ##1 !busy)
		else begin
			$error("busy did not last exactly three cycles");
			fail_count++;
		end

	////////////////////
	// Channel stability
	////////////////////

	a_aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("awvalid or awaddr changed before awready");
			fail_count++;
		end
	a_w_stable: assert property (@(posedge clock) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			$error("wvalid or wdata changed before wready");
			fail_count++;
		end
	a_b_hold: assert property (@(posedge clock) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end
	a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			$error("rvalid or rdata changed before rready");
			fail_count++;
		end
	a_b_rise: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && awready |=> bvalid)
		else begin
			$error("bvalid late after write acceptance");
			fail_count++;
		end
	a_r_rise: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && arready |=> rvalid)
		else begin
			$error("rvalid late after read acceptance");
			fail_count++;
		end

endmodule

bind simd_lane_top simd_lane_props u_props (
	.clock     (clock),
	.rst_n     (rst_n),
	.awvalid   (awvalid),
	.awready   (awready),
	.awaddr    (awaddr),
	.wvalid    (wvalid),
	.wready    (wready),
	.wdata     (wdata),
	.bvalid    (bvalid),
	.bready    (bready),
	.arvalid   (arvalid),
	.arready   (arready),
	.rvalid    (rvalid),
	.rready    (rready),
	.rdata     (rdata),
	.busy      (busy),
	.cmd_valid (cmd_valid)
);

//--- testbench/tb_simd_lane.sv
////////////////////
// SIMD lane array testbench
////////////////////

module tb_simd_lane;
	timeunit 1ns;
	timeprecision 100ps;

	import tpu_types_pkg::*;
	import tpu_isa_pkg::*;

	localparam int NUM_LANES      = 4;
	localparam int NUM_INSTR      = 18;				// 6 local, 8 rotation, 2 scalar, 2 back to back
	localparam int NUM_OPS        = 36 + 64 + 2 + NUM_INSTR * 8;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 200;

	logic      clock;
	logic      rst_n;
	logic      awvalid;
	logic      awready;
	axi_addr_t awaddr;
	logic      wvalid;
	logic      wready;
	data_t     wdata;
	logic      bvalid;
	logic      bready;
	axi_resp_t bresp;
	logic      arvalid;
	logic      arready;
	axi_addr_t araddr;
	logic      rvalid;
	logic      rready;
	data_t     rdata;
	axi_resp_t rresp;

	data_t model_regs [NUM_LANES][NUM_REGS];	// Expected register contents
	data_t model_scalar;
	data_t rng_state;
	int    checks;
	int    errors;

	simd_lane_top #(
		.NUM_LANES (NUM_LANES)
	) dut0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	always #5 clock = ~clock;

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic data_t next_rand();
		rng_state = rng_state ^ (rng_state << 13);	// xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic axi_addr_t reg_addr(input int lane, input int r);
		return ADDR_REG_BASE + axi_addr_t'((lane * 8 + r) * 4);
	endfunction

	function automatic data_t make_instr(input logic [2:0] op, input reg_idx_t dst,
			input reg_idx_t s1, input reg_idx_t s2, input path_t sp, input path_t wp);
		data_t word;
		word        = '0;
		word[2:0]   = op;
		word[6:4]   = dst;
		word[10:8]  = s1;
		word[14:12] = s2;
		word[20:16] = sp;
		word[28:24] = wp;
		return word;
	endfunction

	// Entered and left 1 ns after a rising edge
	task automatic axi_write(input axi_addr_t addr, input data_t data, output axi_resp_t resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clock);
		while (!(awready && wready)) @(negedge clock);
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge clock);
		while (!bvalid) @(negedge clock);
		@(posedge clock);		// Response waits one cycle for bready
		#1;
		bready = 1'b1;
		resp   = bresp;
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input axi_addr_t addr, output data_t data, output axi_resp_t resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clock);
		while (!arready) @(negedge clock);
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		@(negedge clock);
		while (!rvalid) @(negedge clock);
		@(posedge clock);		// Response waits one cycle for rready
		#1;
		rready = 1'b1;
		data   = rdata;
		resp   = rresp;
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Error: %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic data_t alu_model(input logic [2:0] op, input data_t a, input data_t b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_MUL:  return a * b;
			OP_AND:  return a & b;
			OP_XOR:  return a ^ b;
			OP_PASS: return a;
			default: return '0;
		endcase
	endfunction

	function automatic void model_exec(input data_t word);
		data_t s1  [NUM_LANES];
		data_t s2  [NUM_LANES];
		data_t res [NUM_LANES];
		data_t wb  [NUM_LANES];
		data_t a;
		data_t b;
		path_t sp;
		path_t wp;
		int    rs;
		int    rw;
		sp = word[20:16];
		wp = word[28:24];
		rs = int'(sp[1:0]);		// Only the lane-number bits rotate
		rw = int'(wp[1:0]);
		for (int l = 0; l < NUM_LANES; l++) begin
			s1[l] = model_regs[l][word[10:8]];
			s2[l] = model_regs[l][word[14:12]];
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (sp[4]) begin
				a = s1[(l + rs) % NUM_LANES];
				b = s2[(l + rs) % NUM_LANES];
			end else begin
				b = s2[l];
				case (sp[1:0])
					2'd0:    a = model_scalar;
					2'd1:    a = s1[l];
					default: a = s2[l];
				endcase
			end
			res[l] = alu_model(word[2:0], a, b);
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (wp[4]) begin
				wb[l] = res[(l + rw) % NUM_LANES];
			end else begin
				case (wp[1:0])
					2'd0:    wb[l] = res[l];
					2'd1:    wb[l] = s1[l];
					default: wb[l] = s2[l];
				endcase
			end
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			model_regs[l][word[6:4]] = wb[l];
		end
	endfunction

	////////////////////
	// Instruction flow
	////////////////////

	task automatic wait_idle();
		data_t     status;
		axi_resp_t resp;
		status = 32'd1;
		while (status[0]) axi_read(ADDR_STATUS, status, resp);
	endtask

	task automatic check_dst(input string name, input reg_idx_t dst);
		data_t     rd;
		axi_resp_t resp;
		for (int l = 0; l < NUM_LANES; l++) begin
			axi_read(reg_addr(l, int'(dst)), rd, resp);
			check_value($sformatf("%s lane %0d r%0d", name, l, dst), model_regs[l][dst], rd);
		end
	endtask

	task automatic run_instr(input string name, input data_t word);
		axi_resp_t resp;
		axi_write(ADDR_CMD, word, resp);
		check_value({name, " bresp"}, data_t'(RESP_OKAY), data_t'(resp));
		wait_idle();
		model_exec(word);
		check_dst(name, word[6:4]);
	endtask

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		data_t     rd;
		data_t     r;
		data_t     w1;
		data_t     w2;
		axi_resp_t resp;
		int        total;
		clock        = 1'b0;
		rst_n        = 1'b0;
		awvalid      = 1'b0;
		awaddr       = '0;
		wvalid       = 1'b0;
		wdata        = '0;
		bready       = 1'b0;
		arvalid      = 1'b0;
		araddr       = '0;
		rready       = 1'b0;
		rng_state    = 32'd91;
		model_scalar = '0;
		checks       = 0;
		errors       = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int g = 0; g < NUM_REGS; g++) begin
				model_regs[l][g] = '0;
			end
		end
		repeat (2) @(posedge clock);
		#1;
		rst_n = 1'b1;

		// Reset values and address map
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int g = 0; g < NUM_REGS; g++) begin
				axi_read(reg_addr(l, g), rd, resp);
				check_value($sformatf("reset lane %0d r%0d", l, g), '0, rd);
			end
		end
		axi_read(ADDR_STATUS, rd, resp);
		check_value("reset status", '0, rd);
		axi_write(12'h200, 32'hdead_beef, resp);
		check_value("unmapped bresp", data_t'(RESP_SLVERR), data_t'(resp));
		axi_read(12'h10c, rd, resp);
		check_value("unmapped rresp", data_t'(RESP_SLVERR), data_t'(resp));
		check_value("unmapped rdata", '0, rd);

		// Preload every register
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int g = 0; g < NUM_REGS; g++) begin
				model_regs[l][g] = next_rand();
				axi_write(reg_addr(l, g), model_regs[l][g], resp);
			end
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int g = 0; g < NUM_REGS; g++) begin
				axi_read(reg_addr(l, g), rd, resp);
				check_value($sformatf("preload lane %0d r%0d", l, g), model_regs[l][g], rd);
			end
		end

		// Local sources, ALU write-back
		for (int op = 0; op < 6; op++) begin
			r = next_rand();
			run_instr($sformatf("local op %0d", op),
				make_instr(3'(op), r[2:0], r[6:4], r[10:8], path_t'(PATH_SRC1), '0));
		end

		// Cross-lane rotation, upper rotation bits random
		for (int rot = 0; rot < 4; rot++) begin
			r = next_rand();
			run_instr($sformatf("src rot %0d", rot),
				make_instr(3'(r[18:16] % 6), r[2:0], r[6:4], r[10:8],
				{1'b1, r[13:12], lane_idx_t'(rot)}, '0));
			r = next_rand();
			run_instr($sformatf("wb rot %0d", rot),
				make_instr(3'(r[18:16] % 6), r[2:0], r[6:4], r[10:8],
				path_t'(PATH_SRC1), {1'b1, r[13:12], lane_idx_t'(rot)}));
		end

		// Scalar broadcast
		model_scalar = next_rand();
		axi_write(ADDR_SCALAR, model_scalar, resp);
		axi_read(ADDR_SCALAR, rd, resp);
		check_value("scalar readback", model_scalar, rd);
		r = next_rand();
		run_instr("scalar pass", make_instr(OP_PASS, r[2:0], r[6:4], r[10:8], '0, '0));
		r = next_rand();
		run_instr("scalar add", make_instr(OP_ADD, r[2:0], r[6:4], r[10:8], '0, '0));

		// Second command stalls behind the first, own destination
		r  = next_rand();
		w1 = make_instr(3'(r[18:16] % 6), r[2:0], r[6:4], r[10:8], path_t'(PATH_SRC1), '0);
		r  = next_rand();
		w2 = make_instr(3'(r[18:16] % 6), reg_idx_t'(w1[6:4] + 3'd1), r[6:4], r[10:8],
			path_t'(PATH_SRC1), '0);
		axi_write(ADDR_CMD, w1, resp);
		axi_write(ADDR_CMD, w2, resp);
		wait_idle();
		model_exec(w1);
		model_exec(w2);
		check_dst("back to back first", w1[6:4]);
		check_dst("back to back second", w2[6:4]);

		total = errors + dut0.u_props.fail_count;
		$display("Summary: %0d checks, %0d value errors, %0d assertion failures",
			checks, errors, dut0.u_props.fail_count);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
